// ==== source/gpif_params.svh ====
//////////////////////////////
// Frame length and FIFO depths of the bridge
// Host frames are fixed length, every packet starts on a frame
// FIFO depths are given as powers of two
//////////////////////////////

`ifndef GPIF_PARAMS_SVH
`define GPIF_PARAMS_SVH

// Host frame length in 16-bit words
`define GPIF_FRAME_WORDS 16

// Line FIFO depth, log2 of the entry count
`define TX_FIFO_DEPTH_LOG2 4
`define RX_FIFO_DEPTH_LOG2 4

`endif

// ==== source/gpif_bus_pkg.sv ====
//////////////////////////////
// Host bus types: words, packet lengths, frame positions
// Frame position counts 0 .. GPIF_FRAME_WORDS-1 and wraps
//////////////////////////////
`default_nettype none

`include "gpif_params.svh"

package gpif_bus_pkg;

   localparam int unsigned GPIF_WORD_W = 16;
   localparam int unsigned FRAME_POS_W = $clog2(`GPIF_FRAME_WORDS + 1);

   typedef logic [GPIF_WORD_W-1:0] gpif_word_t;
   typedef logic [FRAME_POS_W-1:0] frame_pos_t;
   typedef logic [15:0]            pkt_len_t;

   // Position of the last word in a frame
   localparam frame_pos_t FRAME_LAST = frame_pos_t'(`GPIF_FRAME_WORDS - 1);

endpackage

`default_nettype wire

// ==== source/stream_pkg.sv ====
//////////////////////////////
// Word lines (19 bit) and stream lines (36 bit)
// Earlier word sits in the low half of a 36-bit line
// Bit 18 of a word line is unused and kept zero
//////////////////////////////
`default_nettype none

package stream_pkg;

   typedef logic [18:0] line19_t;
   typedef logic [35:0] line36_t;
   typedef logic [1:0]  occ_t;

   // Word line flags
   localparam int unsigned L19_SOP = 16;
   localparam int unsigned L19_EOP = 17;

   // Stream line flags and occupancy field
   localparam int unsigned L36_SOP     = 32;
   localparam int unsigned L36_EOP     = 33;
   localparam int unsigned L36_OCC_LSB = 34;

   // Occupancy codes
   localparam occ_t OCC_FULL = 2'd0;
   localparam occ_t OCC_LOW  = 2'd1;

endpackage

`default_nettype wire

// ==== source/gpif_wr_port.sv ====
//////////////////////////////
// Host write side, two-entry word buffer
// Host must sample gpif_full_o before writing
// Writes while full are dropped
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module gpif_wr_port
   import gpif_bus_pkg::*;
   import stream_pkg::*;
(
   input  logic       gpif_clk_i,
   input  logic       arst_n_i,
   input  logic       gpif_wr_i,
   input  gpif_word_t gpif_d_i,
   output logic       gpif_full_o,
   output line19_t    data_o,
   output logic       src_rdy_o,
   input  logic       dst_rdy_i
);

   line19_t    entry_q [2];
   logic       wr_ptr_q;
   logic       rd_ptr_q;
   logic [1:0] count_q;
   frame_pos_t pos_q;
   logic       accept;
   logic       pop;

   assign gpif_full_o = (count_q == 2'd2);
   assign src_rdy_o   = (count_q != 2'd0);
   assign data_o      = entry_q[rd_ptr_q];
   assign accept      = gpif_wr_i && !gpif_full_o;
   assign pop         = src_rdy_o && dst_rdy_i;

   always_ff @(posedge gpif_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= 1'b0;
         rd_ptr_q <= 1'b0;
         count_q  <= 2'd0;
         pos_q    <= '0;
      end else begin
         if (accept) begin
            wr_ptr_q <= !wr_ptr_q;
            // Frame position follows host writes
            pos_q    <= (pos_q == FRAME_LAST) ? '0 : pos_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= !rd_ptr_q;
         end
         case ({accept, pop})
            2'b10:   count_q <= count_q + 2'd1;
            2'b01:   count_q <= count_q - 2'd1;
            default: count_q <= count_q;
         endcase
      end
   end

   // Frame start and end marks come from the write position
   always_ff @(posedge gpif_clk_i) begin
      if (accept) begin
         entry_q[wr_ptr_q] <= {1'b0, pos_q == FRAME_LAST, pos_q == '0, gpif_d_i};
      end
   end

endmodule

`default_nettype wire

// ==== source/packet_reframer.sv ====
//////////////////////////////
// Cuts packets out of fixed host frames
// Every packet starts at a frame start with its length word
// Length counts words and includes the length word
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module packet_reframer
   import gpif_bus_pkg::*;
   import stream_pkg::*;
(
   input  logic    gpif_clk_i,
   input  logic    arst_n_i,
   input  line19_t data_i,
   input  logic    src_rdy_i,
   output logic    dst_rdy_o,
   output line19_t data_o,
   output logic    src_rdy_o,
   input  logic    dst_rdy_i
);

   typedef enum logic [1:0] {ST_LEN, ST_PAYLOAD, ST_DROP} state_t;

   state_t     state_q;
   pkt_len_t   rem_q;
   line19_t    out_q;
   logic       out_vld_q;
   logic       accept;
   logic       frame_end;
   logic       keep;
   logic       last;
   gpif_word_t in_word;
   pkt_len_t   len_in;

   assign dst_rdy_o = !out_vld_q || dst_rdy_i;
   assign accept    = src_rdy_i && dst_rdy_o;
   assign frame_end = data_i[L19_EOP];
   assign in_word   = data_i[15:0];
   assign len_in    = pkt_len_t'(in_word);
   assign keep      = (state_q != ST_DROP);
   // A length of 0 or 1 ends the packet on the length word
   assign last      = (state_q == ST_LEN) ? (len_in <= 16'd1) : (rem_q == 16'd1);

   assign data_o    = out_q;
   assign src_rdy_o = out_vld_q;

   always_ff @(posedge gpif_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q   <= ST_LEN;
         rem_q     <= '0;
         out_vld_q <= 1'b0;
      end else begin
         if (accept && keep) begin
            out_vld_q <= 1'b1;
         end else if (dst_rdy_i) begin
            out_vld_q <= 1'b0;
         end

         if (accept) begin
            if (state_q == ST_LEN) begin
               rem_q <= len_in - 16'd1;
            end else if (state_q == ST_PAYLOAD) begin
               rem_q <= rem_q - 16'd1;
            end

            if (keep && last) begin
               state_q <= frame_end ? ST_LEN : ST_DROP;
            end else if (keep) begin
               // Frame end mid packet, next frame carries more payload
               state_q <= ST_PAYLOAD;
            end else if (frame_end) begin
               state_q <= ST_LEN;
            end
         end
      end
   end

   always_ff @(posedge gpif_clk_i) begin
      if (accept && keep) begin
         out_q <= {1'b0, last, state_q == ST_LEN, in_word};
      end
   end

endmodule

`default_nettype wire

// ==== source/line19_to_36.sv ====
//////////////////////////////
// Packs word pairs into stream lines, low half first
// Odd packets end with a half line, occupancy 1
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module line19_to_36
   import gpif_bus_pkg::*;
   import stream_pkg::*;
(
   input  logic    gpif_clk_i,
   input  logic    arst_n_i,
   input  line19_t data_i,
   input  logic    src_rdy_i,
   output logic    dst_rdy_o,
   output line36_t data_o,
   output logic    src_rdy_o,
   input  logic    dst_rdy_i
);

   logic       have_low_q;
   gpif_word_t low_q;
   logic       low_sop_q;
   line36_t    out_q;
   logic       out_vld_q;
   logic       accept;
   logic       in_eop;
   logic       emit;

   assign dst_rdy_o = !out_vld_q || dst_rdy_i;
   assign accept    = src_rdy_i && dst_rdy_o;
   assign in_eop    = data_i[L19_EOP];
   // A line is complete on the high word or on an early packet end
   assign emit      = accept && (have_low_q || in_eop);

   assign data_o    = out_q;
   assign src_rdy_o = out_vld_q;

   always_ff @(posedge gpif_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         have_low_q <= 1'b0;
         out_vld_q  <= 1'b0;
      end else begin
         if (accept) begin
            have_low_q <= !have_low_q && !in_eop;
         end
         if (emit) begin
            out_vld_q <= 1'b1;
         end else if (dst_rdy_i) begin
            out_vld_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge gpif_clk_i) begin
      if (accept && !have_low_q) begin
         low_q     <= data_i[15:0];
         low_sop_q <= data_i[L19_SOP];
      end
      if (emit) begin
         if (have_low_q) begin
            out_q <= {OCC_FULL, in_eop, low_sop_q, data_i[15:0], low_q};
         end else begin
            out_q <= {OCC_LOW, 1'b1, data_i[L19_SOP], 16'h0000, data_i[15:0]};
         end
      end
   end

endmodule

`default_nettype wire

// ==== source/stream_fifo.sv ====
//////////////////////////////
// First-word-fall-through FIFO with output register
// Holds 2**DEPTH_LOG2 lines plus the output line
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
   parameter int unsigned WIDTH      = 36,
   parameter int unsigned DEPTH_LOG2 = 4
) (
   input  logic             gpif_clk_i,
   input  logic             arst_n_i,
   input  logic [WIDTH-1:0] data_i,
   input  logic             src_rdy_i,
   output logic             dst_rdy_o,
   output logic [WIDTH-1:0] data_o,
   output logic             src_rdy_o,
   input  logic             dst_rdy_i
);

   logic [WIDTH-1:0]    mem_q [2**DEPTH_LOG2];
   logic [DEPTH_LOG2:0] wr_ptr_q;
   logic [DEPTH_LOG2:0] rd_ptr_q;
   logic [WIDTH-1:0]    out_q;
   logic                out_vld_q;
   logic                mem_empty;
   logic                mem_full;
   logic                push;
   logic                load;
   logic                mem_wr;

   assign mem_empty = (wr_ptr_q == rd_ptr_q);
   assign mem_full  = (wr_ptr_q[DEPTH_LOG2-1:0] == rd_ptr_q[DEPTH_LOG2-1:0])
                      && (wr_ptr_q[DEPTH_LOG2] != rd_ptr_q[DEPTH_LOG2]);
   assign dst_rdy_o = !mem_full;
   assign push      = src_rdy_i && dst_rdy_o;
   // Output register is free or handing its line over
   assign load      = !out_vld_q || dst_rdy_i;
   // Bypass the memory when it is empty and the output can take the line
   assign mem_wr    = push && !(load && mem_empty);

   assign data_o    = out_q;
   assign src_rdy_o = out_vld_q;

   always_ff @(posedge gpif_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q  <= '0;
         rd_ptr_q  <= '0;
         out_vld_q <= 1'b0;
      end else begin
         if (mem_wr) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (load) begin
            if (!mem_empty) begin
               rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            out_vld_q <= !mem_empty || push;
         end
      end
   end

   always_ff @(posedge gpif_clk_i) begin
      if (mem_wr) begin
         mem_q[wr_ptr_q[DEPTH_LOG2-1:0]] <= data_i;
      end
      if (load) begin
         if (!mem_empty) begin
            out_q <= mem_q[rd_ptr_q[DEPTH_LOG2-1:0]];
         end else if (push) begin
            out_q <= data_i;
         end
      end
   end

endmodule

`default_nettype wire

// ==== source/line36_to_19.sv ====
//////////////////////////////
// Splits stream lines into word lines, low half first
// Occupancy 1 means only the low half is sent
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module line36_to_19
   import stream_pkg::*;
(
   input  logic    gpif_clk_i,
   input  logic    arst_n_i,
   input  line36_t data_i,
   input  logic    src_rdy_i,
   output logic    dst_rdy_o,
   output line19_t data_o,
   output logic    src_rdy_o,
   input  logic    dst_rdy_i
);

   logic half_q;
   occ_t occ;
   logic occ_low;
   logic last_word;

   assign occ       = data_i[L36_OCC_LSB +: 2];
   assign occ_low   = (occ == OCC_LOW);
   assign last_word = half_q || occ_low;

   assign src_rdy_o = src_rdy_i;
   // Line leaves the FIFO with its last valid word
   assign dst_rdy_o = dst_rdy_i && last_word;

   always_comb begin
      if (half_q) begin
         data_o = {1'b0, data_i[L36_EOP], 1'b0, data_i[31:16]};
      end else begin
         data_o = {1'b0, data_i[L36_EOP] && occ_low, data_i[L36_SOP], data_i[15:0]};
      end
   end

   always_ff @(posedge gpif_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         half_q <= 1'b0;
      end else if (src_rdy_i && dst_rdy_i) begin
         half_q <= !last_word;
      end
   end

endmodule

`default_nettype wire

// ==== source/gpif_rd_port.sv ====
//////////////////////////////
// Host read side, one registered word
// Packets are padded with zeros to the frame end
// Host reads only while gpif_empty_o is low
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module gpif_rd_port
   import gpif_bus_pkg::*;
   import stream_pkg::*;
(
   input  logic       gpif_clk_i,
   input  logic       arst_n_i,
   input  line19_t    data_i,
   input  logic       src_rdy_i,
   output logic       dst_rdy_o,
   input  logic       gpif_rd_i,
   output gpif_word_t gpif_d_o,
   output logic       gpif_empty_o
);

   typedef enum logic {ST_PKT, ST_PAD} state_t;

   state_t     state_q;
   frame_pos_t pos_q;
   logic       vld_q;
   gpif_word_t word_q;
   logic       load;
   logic       accept;
   logic       pad_load;
   logic       frame_last;

   // Host word register is free or being read
   assign load       = !vld_q || gpif_rd_i;
   assign dst_rdy_o  = (state_q == ST_PKT) && load;
   assign accept     = src_rdy_i && dst_rdy_o;
   assign pad_load   = (state_q == ST_PAD) && load;
   // Position of the word about to be loaded
   assign frame_last = (pos_q == FRAME_LAST);

   assign gpif_empty_o = !vld_q;
   assign gpif_d_o     = word_q;

   always_ff @(posedge gpif_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= ST_PKT;
         pos_q   <= '0;
         vld_q   <= 1'b0;
      end else begin
         if (accept || pad_load) begin
            vld_q <= 1'b1;
            pos_q <= frame_last ? '0 : pos_q + 1'b1;
         end else if (gpif_rd_i) begin
            vld_q <= 1'b0;
         end

         // Packet ending on the frame end needs no padding
         if (accept && data_i[L19_EOP] && !frame_last) begin
            state_q <= ST_PAD;
         end
         if (pad_load && frame_last) begin
            state_q <= ST_PKT;
         end
      end
   end

   always_ff @(posedge gpif_clk_i) begin
      if (accept) begin
         word_q <= data_i[15:0];
      end else if (pad_load) begin
         word_q <= '0;
      end
   end

endmodule

`default_nettype wire

// ==== source/gpif_bridge.sv ====
//////////////////////////////
// Host bus to stream bridge, single clock
// Host data pin is split into gpif_d_i and gpif_d_o
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "gpif_params.svh"

module gpif_bridge
   import gpif_bus_pkg::*;
   import stream_pkg::*;
(
   input  logic       gpif_clk_i,
   input  logic       arst_n_i,
   input  logic       gpif_wr_i,
   input  gpif_word_t gpif_d_i,
   output logic       gpif_full_o,
   input  logic       gpif_rd_i,
   output gpif_word_t gpif_d_o,
   output logic       gpif_empty_o,
   output line36_t    tx_data_o,
   output logic       tx_src_rdy_o,
   input  logic       tx_dst_rdy_i,
   input  line36_t    rx_data_i,
   input  logic       rx_src_rdy_i,
   output logic       rx_dst_rdy_o
);

   //////////////////////////////
   // TX path

   line19_t wr19_data, refr_data;
   logic    wr19_src_rdy, wr19_dst_rdy, refr_src_rdy, refr_dst_rdy;
   line36_t tx36_data;
   logic    tx36_src_rdy, tx36_dst_rdy;

   gpif_wr_port u_wr_port (
      .gpif_clk_i, .arst_n_i, .gpif_wr_i, .gpif_d_i, .gpif_full_o,
      .data_o(wr19_data), .src_rdy_o(wr19_src_rdy), .dst_rdy_i(wr19_dst_rdy));

   packet_reframer u_reframer (
      .gpif_clk_i, .arst_n_i,
      .data_i(wr19_data), .src_rdy_i(wr19_src_rdy), .dst_rdy_o(wr19_dst_rdy),
      .data_o(refr_data), .src_rdy_o(refr_src_rdy), .dst_rdy_i(refr_dst_rdy));

   line19_to_36 u_pack (
      .gpif_clk_i, .arst_n_i,
      .data_i(refr_data), .src_rdy_i(refr_src_rdy), .dst_rdy_o(refr_dst_rdy),
      .data_o(tx36_data), .src_rdy_o(tx36_src_rdy), .dst_rdy_i(tx36_dst_rdy));

   stream_fifo #(.WIDTH($bits(line36_t)), .DEPTH_LOG2(`TX_FIFO_DEPTH_LOG2)) tx_fifo (
      .gpif_clk_i, .arst_n_i,
      .data_i(tx36_data), .src_rdy_i(tx36_src_rdy), .dst_rdy_o(tx36_dst_rdy),
      .data_o(tx_data_o), .src_rdy_o(tx_src_rdy_o), .dst_rdy_i(tx_dst_rdy_i));

   //////////////////////////////
   // RX path

   line36_t rx36_data;
   logic    rx36_src_rdy, rx36_dst_rdy;
   line19_t rx19_data;
   logic    rx19_src_rdy, rx19_dst_rdy;

   stream_fifo #(.WIDTH($bits(line36_t)), .DEPTH_LOG2(`RX_FIFO_DEPTH_LOG2)) rx_fifo (
      .gpif_clk_i, .arst_n_i,
      .data_i(rx_data_i), .src_rdy_i(rx_src_rdy_i), .dst_rdy_o(rx_dst_rdy_o),
      .data_o(rx36_data), .src_rdy_o(rx36_src_rdy), .dst_rdy_i(rx36_dst_rdy));

   line36_to_19 u_split (
      .gpif_clk_i, .arst_n_i,
      .data_i(rx36_data), .src_rdy_i(rx36_src_rdy), .dst_rdy_o(rx36_dst_rdy),
      .data_o(rx19_data), .src_rdy_o(rx19_src_rdy), .dst_rdy_i(rx19_dst_rdy));

   gpif_rd_port u_rd_port (
      .gpif_clk_i, .arst_n_i,
      .data_i(rx19_data), .src_rdy_i(rx19_src_rdy), .dst_rdy_o(rx19_dst_rdy),
      .gpif_rd_i, .gpif_d_o, .gpif_empty_o);

endmodule

`default_nettype wire

// ==== verif/gpif_bridge_tb.sv ====
//////////////////////////////
// Testbench for the host-bus bridge
// Inputs change on falling edges and transfers happen on rising edges
// TX back-pressure and RX read gaps come from $urandom with seed 19954
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "gpif_params.svh"

module gpif_bridge_tb
   import gpif_bus_pkg::*;
   import stream_pkg::*;
();

   localparam int CLK_PERIOD   = 8;
   localparam int RESET_CYCLES = 5;
   localparam int FW           = `GPIF_FRAME_WORDS;
   // Idle time after a TX test that lets any stray line reach the output
   localparam int DRAIN_CYCLES = 8;
   // Worst case cycles of reset, two TX frame tests, TX stall, RX pad and RX stall
   localparam int TEST_CYCLES     = 10 + 60 + 80 + 700 + 60 + 300 + 3 * DRAIN_CYCLES;
   localparam int WATCHDOG_CYCLES = (RESET_CYCLES + TEST_CYCLES) * 4;

   logic       gpif_clk = 1'b0;
   logic       arst_n;
   logic       gpif_wr;
   gpif_word_t gpif_d;
   logic       gpif_full;
   logic       gpif_rd;
   gpif_word_t gpif_q;
   logic       gpif_empty;
   line36_t    tx_data;
   logic       tx_src_rdy;
   logic       tx_dst_rdy;
   line36_t    rx_data;
   logic       rx_src_rdy;
   logic       rx_dst_rdy;

   // Expected values and stimulus
   line36_t    tx_exp [$];
   gpif_word_t tx_words [$];
   line36_t    rx_lines [$];
   gpif_word_t rx_exp [$];

   int    errors = 0;
   int    tx_hold_errors = 0;
   int    rx_hold_errors = 0;
   int    full_cycles = 0;
   int    rx_stall_cycles = 0;
   int    tests_run = 0;
   int    tests_failed = 0;
   int    test_start_errors = 0;
   string test_name = "none";

   gpif_bridge uut (
      .gpif_clk_i(gpif_clk), .arst_n_i(arst_n),
      .gpif_wr_i(gpif_wr), .gpif_d_i(gpif_d), .gpif_full_o(gpif_full),
      .gpif_rd_i(gpif_rd), .gpif_d_o(gpif_q), .gpif_empty_o(gpif_empty),
      .tx_data_o(tx_data), .tx_src_rdy_o(tx_src_rdy), .tx_dst_rdy_i(tx_dst_rdy),
      .rx_data_i(rx_data), .rx_src_rdy_i(rx_src_rdy), .rx_dst_rdy_o(rx_dst_rdy));

   always #(CLK_PERIOD / 2) gpif_clk = !gpif_clk;

   always @(posedge gpif_clk) begin
      if (arst_n && gpif_full) begin
         full_cycles++;
      end
      if (arst_n && !rx_dst_rdy) begin
         rx_stall_cycles++;
      end
   end

   //////////////////////////////
   // Stream and host bus rules

   tx_hold_a: assert property (@(posedge gpif_clk) disable iff (!arst_n)
      $past(tx_src_rdy && !tx_dst_rdy) |-> tx_src_rdy && (tx_data == $past(tx_data)))
   else begin
      tx_hold_errors++;
      $display("TX line dropped or changed while stalled in %s", test_name);
   end

   rx_hold_a: assert property (@(posedge gpif_clk) disable iff (!arst_n)
      $past(!gpif_empty && !gpif_rd) |-> !gpif_empty && (gpif_q == $past(gpif_q)))
   else begin
      rx_hold_errors++;
      $display("host word dropped or changed before it was read in %s", test_name);
   end

   function automatic int total_errors();
      return errors + tx_hold_errors + rx_hold_errors;
   endfunction

   function automatic bit line_matches(input line36_t expv, input line36_t actv);
      // High half of a half line carries no data
      if (expv[L36_OCC_LSB +: 2] == OCC_LOW) begin
         return {expv[35:32], expv[15:0]} == {actv[35:32], actv[15:0]};
      end
      return expv == actv;
   endfunction

   task automatic start_test(input string name);
      test_name         = name;
      test_start_errors = total_errors();
   endtask

   task automatic end_test();
      int errs;
      errs = total_errors() - test_start_errors;
      tests_run++;
      if (errs != 0) begin
         tests_failed++;
      end
      $display("test %0d %s: %s, %0d errors", tests_run, test_name,
               (errs == 0) ? "passed" : "FAILED", errs);
   endtask

   //////////////////////////////
   // TX side

   task automatic queue_tx_packet(input int len);
      gpif_word_t words [$];
      line36_t    line;
      int         i;
      words.push_back(gpif_word_t'(len));
      for (i = 1; i < len; i++) begin
         words.push_back(gpif_word_t'($urandom));
      end
      // Kept words in pairs with the earlier word low and an odd tail as a half line
      for (i = 0; i < len; i += 2) begin
         line               = '0;
         line[15:0]         = words[i];
         line[L36_SOP]      = (i == 0);
         line[L36_EOP]      = (i + 2 >= len);
         if (i + 1 < len) begin
            line[31:16] = words[i + 1];
         end else begin
            line[L36_OCC_LSB +: 2] = OCC_LOW;
         end
         tx_exp.push_back(line);
      end
      // Whole frames on the host bus with random padding
      for (i = 0; i < ((len + FW - 1) / FW) * FW; i++) begin
         tx_words.push_back((i < len) ? words[i] : gpif_word_t'($urandom));
      end
   endtask

   task automatic write_frames();
      gpif_word_t w;
      while (tx_words.size() != 0) begin
         w = tx_words.pop_front();
         while (gpif_full) @(negedge gpif_clk);
         gpif_wr = 1'b1;
         gpif_d  = w;
         @(negedge gpif_clk);
         gpif_wr = 1'b0;
      end
   endtask

   task automatic check_tx_lines(input bit stall);
      line36_t expv;
      while (tx_exp.size() != 0) begin
         tx_dst_rdy = stall ? ($urandom % 8 == 0) : 1'b1;
         // Both ready now means the line moves on the next rising edge
         if (tx_src_rdy && tx_dst_rdy) begin
            expv = tx_exp.pop_front();
            assert (line_matches(expv, tx_data)) else begin
               errors++;
               $display("mismatch in %s: expected %h, actual %h", test_name, expv, tx_data);
            end
         end
         @(negedge gpif_clk);
      end
      tx_dst_rdy = 1'b1;
   endtask

   // Padding must never reach the TX stream
   task automatic check_tx_idle();
      repeat (DRAIN_CYCLES) @(negedge gpif_clk);
      assert (!tx_src_rdy) else begin
         errors++;
         $display("extra TX line after the last packet end in %s", test_name);
      end
   endtask

   //////////////////////////////
   // RX side

   task automatic queue_rx_packet(input int n);
      gpif_word_t words [$];
      line36_t    line;
      int         i;
      for (i = 0; i < n; i++) begin
         words.push_back(gpif_word_t'($urandom));
         rx_exp.push_back(words[i]);
      end
      // Zero words up to the frame end
      for (i = n; i % FW != 0; i++) begin
         rx_exp.push_back(16'h0000);
      end
      for (i = 0; i < n; i += 2) begin
         line          = '0;
         line[15:0]    = words[i];
         line[L36_SOP] = (i == 0);
         line[L36_EOP] = (i + 2 >= n);
         if (i + 1 < n) begin
            line[31:16] = words[i + 1];
         end else begin
            line[L36_OCC_LSB +: 2] = OCC_LOW;
         end
         rx_lines.push_back(line);
      end
   endtask

   task automatic send_rx_lines();
      while (rx_lines.size() != 0) begin
         rx_data    = rx_lines.pop_front();
         rx_src_rdy = 1'b1;
         while (!rx_dst_rdy) @(negedge gpif_clk);
         @(negedge gpif_clk);
      end
      rx_src_rdy = 1'b0;
   endtask

   task automatic read_host_words(input int start_delay, input int max_gap);
      gpif_word_t expv;
      repeat (start_delay) @(negedge gpif_clk);
      while (rx_exp.size() != 0) begin
         repeat ($urandom % (max_gap + 1)) @(negedge gpif_clk);
         while (gpif_empty) @(negedge gpif_clk);
         expv = rx_exp.pop_front();
         assert (gpif_q == expv) else begin
            errors++;
            $display("mismatch in %s: expected %h, actual %h", test_name, expv, gpif_q);
         end
         gpif_rd = 1'b1;
         @(negedge gpif_clk);
         gpif_rd = 1'b0;
      end
      assert (gpif_empty) else begin
         errors++;
         $display("gpif_empty_o still low after the frame end in %s", test_name);
      end
   endtask

   initial begin
      int mark;
      arst_n     = 1'b0;
      gpif_wr    = 1'b0;
      gpif_d     = '0;
      gpif_rd    = 1'b0;
      tx_dst_rdy = 1'b1;
      rx_data    = '0;
      rx_src_rdy = 1'b0;
      void'($urandom(19954));
      repeat (RESET_CYCLES) @(negedge gpif_clk);
      arst_n = 1'b1;
      @(negedge gpif_clk);

      start_test("reset");
      assert ({gpif_full, tx_src_rdy, gpif_empty, rx_dst_rdy} == 4'b0011) else begin
         errors++;
         $display("mismatch in %s: expected %b, actual %b", test_name, 4'b0011,
                  {gpif_full, tx_src_rdy, gpif_empty, rx_dst_rdy});
      end
      end_test();

      start_test("tx_even");
      queue_tx_packet(10);
      fork
         write_frames();
         check_tx_lines(1'b0);
      join
      check_tx_idle();
      end_test();

      start_test("tx_join");
      queue_tx_packet(21);
      fork
         write_frames();
         check_tx_lines(1'b0);
      join
      check_tx_idle();
      end_test();

      start_test("tx_stall");
      mark = full_cycles;
      queue_tx_packet(32);
      queue_tx_packet(32);
      queue_tx_packet(21);
      queue_tx_packet(16);
      fork
         write_frames();
         check_tx_lines(1'b1);
      join
      check_tx_idle();
      assert (full_cycles != mark) else begin
         errors++;
         $display("gpif_full_o never rose in %s", test_name);
      end
      end_test();

      start_test("rx_pad");
      queue_rx_packet(7);
      fork
         send_rx_lines();
         read_host_words(0, 0);
      join
      end_test();

      start_test("rx_stall");
      mark = rx_stall_cycles;
      queue_rx_packet(40);
      queue_rx_packet(3);
      fork
         send_rx_lines();
         read_host_words(60, 3);
      join
      assert (rx_stall_cycles != mark) else begin
         errors++;
         $display("rx_dst_rdy_o never fell in %s", test_name);
      end
      end_test();

      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
               total_errors());
      if (total_errors() == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   // Run limit from the summed test budgets
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge gpif_clk);
      $display("watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, test_name);
      $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+source
source/gpif_bus_pkg.sv
source/stream_pkg.sv
source/gpif_wr_port.sv
source/packet_reframer.sv
source/line19_to_36.sv
source/stream_fifo.sv
source/line36_to_19.sv
source/gpif_rd_port.sv
source/gpif_bridge.sv
verif/gpif_bridge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the bridge testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module gpif_bridge_tb \
   && ./obj_dir/Vgpif_bridge_tb > sim.log 2>&1 \
   && cat sim.log \
   && ! grep -q "Done: errors found" sim.log \
   && echo "simulation passed" \
   || { cat sim.log 2>/dev/null; echo "simulation failed"; exit 1; }
